// File: files.f
+incdir+src
src/bus_types_pkg.sv
src/periph_types_pkg.sv
src/bus_stage_if.sv
src/apb_front.sv
src/addr_decode.sv
src/periph_access.sv
src/load_align.sv
src/periph_bus_top.sv
tests/periph_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module periph_bus_tb -o periph_bus_sim

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/periph_bus_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// File: src/addr_decode.sv
`timescale 1ns/1ns
`include "periph_bus_config.svh"

module addr_decode (
    input  logic   clk,
    input  logic   rst_n,
    bus_req_if.dst in_req,
    bus_req_if.src out_req
);

    bus_types_pkg::addr_t      word_addr;
    bus_types_pkg::addr_t      ram_off;
    bus_types_pkg::addr_t      sd_off;
    periph_types_pkg::region_e region;

    assign word_addr = {in_req.addr[31:2], 2'b00};
    // Offsets into the two ranged targets, wrap-around keeps the compare one-sided
    assign ram_off = in_req.addr - `RAM_BASE;
    assign sd_off  = in_req.addr - `SD_BASE;

    always_comb begin
        region = periph_types_pkg::none;
        if (ram_off < 4 * `RAM_WORDS) begin
            region = periph_types_pkg::ram;
        end else if (word_addr == `KEY_ADDR) begin
            region = periph_types_pkg::key;
        end else if (word_addr == `UART_ADDR) begin
            region = periph_types_pkg::uart;
        end else if (word_addr == `SD_AVAIL_ADDR) begin
            region = periph_types_pkg::sd_avail;
        end else if (word_addr == `IRQ_ACK_ADDR) begin
            region = periph_types_pkg::irq_ack;
        end else if (sd_off < `SD_BYTES) begin
            region = periph_types_pkg::sd_buf;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req.valid <= 1'b0;
        end else begin
            out_req.valid <= in_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        out_req.write     <= in_req.write;
        out_req.addr      <= in_req.addr;
        out_req.wdata     <= in_req.wdata;
        out_req.strb      <= in_req.strb;
        out_req.load_type <= in_req.load_type;
        out_req.region    <= region;
    end

endmodule

// File: src/apb_front.sv
`timescale 1ns/1ns

module apb_front (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  bus_types_pkg::addr_t      paddr,
    input  bus_types_pkg::data_t      pwdata,
    input  bus_types_pkg::strb_t      pstrb,
    input  bus_types_pkg::load_type_e load_type,
    output bus_types_pkg::data_t      prdata,
    output logic                      pready,
    output logic                      pslverr,
    bus_req_if.src                    req,
    bus_rsp_if.dst                    rsp
);

    logic busy;
    logic setup_phase;

    // Only one transfer in flight, so a new setup is ignored while busy
    assign setup_phase = psel && !penable && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            req.valid <= setup_phase;
            if (setup_phase) begin
                busy <= 1'b1;
            end else if (rsp.valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Transfer fields captured once at the end of setup
    always_ff @(posedge clk) begin
        if (setup_phase) begin
            req.write     <= pwrite;
            req.addr      <= paddr;
            req.wdata     <= pwdata;
            req.strb      <= pstrb;
            req.load_type <= load_type;
        end
    end

    // Response returned in the single cycle it is valid
    assign pready  = rsp.valid;
    assign pslverr = rsp.err;
    assign prdata  = rsp.rdata;

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);

    a_pready_single: assert property (@(posedge clk) disable iff (!rst_n)
        pready |=> !pready);

endmodule

// File: src/bus_stage_if.sv
`timescale 1ns/1ns

// Request travelling down the pipeline
interface bus_req_if;
    logic                       valid;
    logic                       write;
    bus_types_pkg::addr_t       addr;
    bus_types_pkg::data_t       wdata;
    bus_types_pkg::strb_t       strb;
    bus_types_pkg::load_type_e  load_type;
    periph_types_pkg::region_e  region;

    modport src (output valid, write, addr, wdata, strb, load_type, region);
    modport dst (input valid, write, addr, wdata, strb, load_type, region);
endinterface

// Response travelling back to the APB front
interface bus_rsp_if;
    logic                       valid;
    bus_types_pkg::data_t       rdata;
    logic                       err;
    logic [1:0]                 offset;
    bus_types_pkg::load_type_e  load_type;

    modport src (output valid, rdata, err, offset, load_type);
    modport dst (input valid, rdata, err, offset, load_type);
endinterface

// File: src/bus_types_pkg.sv
package bus_types_pkg;

    // Byte address as seen by the requester
    typedef logic [31:0] addr_t;

    // Full bus word
    typedef logic [31:0] data_t;

    // One enable bit per byte lane
    typedef logic [3:0] strb_t;

    // Load size and sign, same codes as the RISC-V funct3 field
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_type_e;

endpackage

// File: src/load_align.sv
`timescale 1ns/1ns

module load_align (
    input  logic   clk,
    input  logic   rst_n,
    bus_rsp_if.dst in_rsp,
    bus_rsp_if.src out_rsp
);

    bus_types_pkg::data_t shifted;
    bus_types_pkg::data_t aligned;

    // Addressed byte or halfword moved down to bit 0
    assign shifted = in_rsp.rdata >> {in_rsp.offset, 3'b000};

    always_comb begin
        case (in_rsp.load_type)
            bus_types_pkg::lb:
                aligned = {{24{shifted[7]}}, shifted[7:0]};
            bus_types_pkg::lh:
                aligned = {{16{shifted[15]}}, shifted[15:0]};
            bus_types_pkg::lbu:
                aligned = {24'b0, shifted[7:0]};
            bus_types_pkg::lhu:
                aligned = {16'b0, shifted[15:0]};
            default:
                aligned = in_rsp.rdata;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_rsp.valid <= 1'b0;
            out_rsp.err   <= 1'b0;
        end else begin
            out_rsp.valid <= in_rsp.valid;
            out_rsp.err   <= in_rsp.err;
        end
    end

    always_ff @(posedge clk) begin
        // Error responses carry no data
        out_rsp.rdata <= in_rsp.err ? '0 : aligned;
    end

endmodule

// File: src/periph_access.sv
`timescale 1ns/1ns
`include "periph_bus_config.svh"

module periph_access (
    input  logic                    clk,
    input  logic                    rst_n,
    bus_req_if.dst                  req,
    bus_rsp_if.src                  rsp,
    input  periph_types_pkg::byte_t key_code,
    input  logic                    key_valid,
    input  periph_types_pkg::byte_t sd_byte,
    input  logic                    sd_byte_valid,
    output periph_types_pkg::byte_t uart_data,
    output logic                    uart_valid,
    output logic                    irq
);

    bus_types_pkg::data_t          ram_mem [0:`RAM_WORDS-1];
    periph_types_pkg::byte_t       sector_buf [0:`SD_BYTES-1];

    periph_types_pkg::byte_t       key_reg;
    periph_types_pkg::sector_idx_t sd_count;
    logic                          sd_available;

    periph_types_pkg::ram_idx_t    ram_idx;
    periph_types_pkg::sector_idx_t sd_rd_idx;
    logic                          sd_store;
    logic                          wr_ram;
    logic                          wr_uart;
    logic                          wr_ack;
    logic                          wr_rearm;
    logic                          bad_access;

    assign ram_idx   = periph_types_pkg::ram_idx_t'((req.addr - `RAM_BASE) >> 2);
    assign sd_rd_idx = periph_types_pkg::sector_idx_t'(req.addr - `SD_BASE);

    // Stream bytes are dropped while a full sector waits for software
    assign sd_store = sd_byte_valid && !sd_available;

    assign wr_ram   = req.valid && req.write && (req.region == periph_types_pkg::ram);
    assign wr_uart  = req.valid && req.write && (req.region == periph_types_pkg::uart);
    assign wr_ack   = req.valid && req.write && (req.region == periph_types_pkg::irq_ack);
    assign wr_rearm = req.valid && req.write && (req.region == periph_types_pkg::sd_avail);

    // Unmapped, or a write to one of the read-only targets
    assign bad_access = (req.region == periph_types_pkg::none) ||
                        (req.write && (req.region == periph_types_pkg::key ||
                                       req.region == periph_types_pkg::sd_buf));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp.valid    <= 1'b0;
            rsp.err      <= 1'b0;
            uart_valid   <= 1'b0;
            irq          <= 1'b0;
            key_reg      <= '0;
            sd_count     <= '0;
            sd_available <= 1'b0;
        end else begin
            rsp.valid  <= req.valid;
            rsp.err    <= req.valid && bad_access;
            uart_valid <= wr_uart;

            if (wr_ack) begin
                irq <= 1'b0;
            end
            // A new key event wins over an acknowledge in the same cycle
            if (key_valid) begin
                key_reg <= key_code;
                irq     <= 1'b1;
            end

            if (wr_rearm) begin
                sd_count     <= '0;
                sd_available <= 1'b0;
            end else if (sd_store) begin
                sd_count <= sd_count + 1'b1;
                if (sd_count == periph_types_pkg::sector_idx_t'(`SD_BYTES - 1)) begin
                    sd_available <= 1'b1;
                end
            end
        end
    end

    // Storage and read data path
    always_ff @(posedge clk) begin
        if (wr_ram) begin
            for (int i = 0; i < 4; i++) begin
                if (req.strb[i]) begin
                    ram_mem[ram_idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end

        if (sd_store && !wr_rearm) begin
            sector_buf[sd_count[8:0]] <= sd_byte;
        end

        if (wr_uart) begin
            uart_data <= req.wdata[7:0];
        end

        rsp.offset    <= req.addr[1:0];
        rsp.load_type <= req.load_type;
        rsp.rdata     <= '0;
        if (req.valid && !req.write) begin
            case (req.region)
                periph_types_pkg::ram:
                    rsp.rdata <= ram_mem[ram_idx];
                periph_types_pkg::key:
                    rsp.rdata <= {24'b0, key_reg};
                periph_types_pkg::sd_avail:
                    rsp.rdata <= {31'b0, sd_available};
                periph_types_pkg::sd_buf:
                    // Byte goes to its own lane so the aligner treats it like RAM
                    rsp.rdata <= bus_types_pkg::data_t'(sector_buf[sd_rd_idx[8:0]])
                                 << {req.addr[1:0], 3'b000};
                default:
                    rsp.rdata <= '0;
            endcase
        end
    end

    a_fill_bound: assert property (@(posedge clk) disable iff (!rst_n)
        sd_count <= periph_types_pkg::sector_idx_t'(`SD_BYTES));

endmodule

// File: src/periph_bus_config.svh
`ifndef PERIPH_BUS_CONFIG_SVH
`define PERIPH_BUS_CONFIG_SVH

// Data RAM, word addressed internally
`define RAM_BASE      32'h0000_0000
`define RAM_WORDS     1024

// Single-word peripheral registers
`define KEY_ADDR      32'h0000_2000
`define UART_ADDR     32'h0000_2004
`define SD_AVAIL_ADDR 32'h0000_2008
`define IRQ_ACK_ADDR  32'h0000_200C

// SD sector buffer, byte addressed
`define SD_BASE       32'h0000_3000
`define SD_BYTES      512

`endif

// File: src/periph_bus_top.sv
`timescale 1ns/1ns

module periph_bus_top (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  bus_types_pkg::addr_t      paddr,
    input  bus_types_pkg::data_t      pwdata,
    input  bus_types_pkg::strb_t      pstrb,
    input  bus_types_pkg::load_type_e load_type,
    output bus_types_pkg::data_t      prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  periph_types_pkg::byte_t   key_code,
    input  logic                      key_valid,
    input  periph_types_pkg::byte_t   sd_byte,
    input  logic                      sd_byte_valid,
    output periph_types_pkg::byte_t   uart_data,
    output logic                      uart_valid,
    output logic                      irq
);

    bus_req_if front_req ();
    bus_req_if dec_req ();
    bus_rsp_if acc_rsp ();
    bus_rsp_if aln_rsp ();

    // Stage 1, APB capture and response
    apb_front apb_front_i (
        .clk       (CLOCK_50),
        .rst_n     (KEY0),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .load_type (load_type),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .req       (front_req.src),
        .rsp       (aln_rsp.dst)
    );

    addr_decode addr_decode_i (
        .clk     (CLOCK_50),
        .rst_n   (KEY0),
        .in_req  (front_req.dst),
        .out_req (dec_req.src)
    );

    periph_access periph_access_i (
        .clk           (CLOCK_50),
        .rst_n         (KEY0),
        .req           (dec_req.dst),
        .rsp           (acc_rsp.src),
        .key_code      (key_code),
        .key_valid     (key_valid),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .uart_data     (uart_data),
        .uart_valid    (uart_valid),
        .irq           (irq)
    );

    load_align load_align_i (
        .clk     (CLOCK_50),
        .rst_n   (KEY0),
        .in_rsp  (acc_rsp.dst),
        .out_rsp (aln_rsp.src)
    );

endmodule

// File: src/periph_types_pkg.sv
package periph_types_pkg;

    // Target selected by the address decoder
    typedef enum logic [2:0] {
        ram,
        key,
        uart,
        sd_avail,
        irq_ack,
        sd_buf,
        none
    } region_e;

    typedef logic [7:0] byte_t;

    // Wide enough to hold the full count of 512
    typedef logic [9:0] sector_idx_t;

    typedef logic [9:0] ram_idx_t;

endpackage

// File: tests/periph_bus_tb.sv
`timescale 1ns/1ns
`include "periph_bus_config.svh"

module periph_bus_tb;

    localparam int RAM_FILL     = 32;
    localparam int RAM_RAND_WR  = 64;
    localparam int RAM_READS    = 96;
    localparam int UART_WRITES  = 8;
    localparam int SD_READS     = 32;
    localparam int EXTRA_BYTES  = 8;
    localparam int REFILL_BYTES = 16;
    localparam int MISC_XFERS   = 40;
    localparam int XFER_COUNT   = RAM_FILL + RAM_RAND_WR + RAM_READS + UART_WRITES
                                  + SD_READS + REFILL_BYTES + MISC_XFERS;
    localparam int STREAM_LEN   = `SD_BYTES + EXTRA_BYTES + REFILL_BYTES;
    localparam int WATCHDOG     = 40 * XFER_COUNT + 2 * STREAM_LEN + 16;
    // pready is sampled high at the fourth edge after the end of setup
    localparam int READY_EDGE   = 4;

    logic                             CLOCK_50;
    logic                             KEY0;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    bus_types_pkg::addr_t             paddr;
    bus_types_pkg::data_t             pwdata;
    bus_types_pkg::strb_t             pstrb;
    bus_types_pkg::load_type_e        load_type;
    bus_types_pkg::data_t             prdata;
    logic                             pready;
    logic                             pslverr;
    periph_types_pkg::byte_t          key_code;
    logic                             key_valid;
    periph_types_pkg::byte_t          sd_byte;
    logic                             sd_byte_valid;
    periph_types_pkg::byte_t          uart_data;
    logic                             uart_valid;
    logic                             irq;

    // Reference model state
    bus_types_pkg::data_t             ram_model [0:`RAM_WORDS-1];
    periph_types_pkg::ram_idx_t       word_list [RAM_FILL];
    periph_types_pkg::byte_t          sector_model [0:`SD_BYTES-1];
    periph_types_pkg::sector_idx_t    sector_count;
    logic                             sector_avail;
    periph_types_pkg::byte_t          key_model;
    logic                             irq_model;
    periph_types_pkg::byte_t          uart_exp [$];
    integer                           seed = 49;

    periph_bus_top periph_bus_top_i (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .pstrb         (pstrb),
        .load_type     (load_type),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .key_code      (key_code),
        .key_valid     (key_valid),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .uart_data     (uart_data),
        .uart_valid    (uart_valid),
        .irq           (irq)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever begin
            #4 CLOCK_50 = ~CLOCK_50;
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge CLOCK_50);
        $display("Error: simulation ran past %0d cycles without finishing", WATCHDOG);
        $display("Test FAILED");
        $fatal(1);
    end

    task automatic stop_on_error(input string why);
        $display("Error: %s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input bus_types_pkg::data_t exp,
                              input bus_types_pkg::data_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_uart(input periph_types_pkg::byte_t exp,
                              input periph_types_pkg::byte_t act);
        if (act !== exp) begin
            $display("Mismatch uart_data: expected 0x%h, got 0x%h", exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Every uart_valid pulse must match the next expected byte
    initial begin
        forever begin
            @(posedge CLOCK_50);
            if (uart_valid === 1'b1) begin
                if (uart_exp.size() == 0) begin
                    stop_on_error("uart_valid pulsed with no UART write pending");
                end else begin
                    check_uart(uart_exp.pop_front(), uart_data);
                end
            end
        end
    end

    function automatic bus_types_pkg::load_type_e load_from_code(input int code);
        case (code)
            0: return bus_types_pkg::lb;
            1: return bus_types_pkg::lh;
            2: return bus_types_pkg::lw;
            3: return bus_types_pkg::lbu;
            default: return bus_types_pkg::lhu;
        endcase
    endfunction

    // Shift by the byte offset, then extend by size and sign
    function automatic bus_types_pkg::data_t expected_load(input bus_types_pkg::data_t word,
            input logic [1:0] off, input bus_types_pkg::load_type_e lt);
        bus_types_pkg::data_t sh;
        sh = word >> (8 * off);
        case (lt)
            bus_types_pkg::lb:  return {{24{sh[7]}}, sh[7:0]};
            bus_types_pkg::lh:  return {{16{sh[15]}}, sh[15:0]};
            bus_types_pkg::lbu: return {24'b0, sh[7:0]};
            bus_types_pkg::lhu: return {16'b0, sh[15:0]};
            default:            return word;
        endcase
    endfunction

    task automatic do_xfer(input logic wr, input bus_types_pkg::addr_t a,
            input bus_types_pkg::data_t wd, input bus_types_pkg::strb_t s,
            input bus_types_pkg::load_type_e lt,
            output bus_types_pkg::data_t rd, output logic err);
        int edges;
        @(posedge CLOCK_50);
        if (pready !== 1'b0) begin
            stop_on_error("pready was not low between transfers");
        end
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= wr;
        paddr     <= a;
        pwdata    <= wd;
        pstrb     <= s;
        load_type <= lt;
        // Edge 0 ends the setup phase
        @(posedge CLOCK_50);
        penable <= 1'b1;
        edges = 0;
        do begin
            @(posedge CLOCK_50);
            edges++;
            if (edges > 40) begin
                stop_on_error("pready never rose during the access phase");
            end
        end while (pready !== 1'b1);
        if (edges != READY_EDGE) begin
            stop_on_error($sformatf("pready rose %0d edges after setup", edges));
        end
        rd = prdata;
        err = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input bus_types_pkg::addr_t a, input bus_types_pkg::data_t wd,
                            input bus_types_pkg::strb_t s);
        bus_types_pkg::data_t rd;
        logic                 err;
        do_xfer(1'b1, a, wd, s, bus_types_pkg::lw, rd, err);
        check_err("pslverr", 1'b0, err);
    endtask

    task automatic read_ok(input bus_types_pkg::addr_t a, input bus_types_pkg::load_type_e lt,
                           input bus_types_pkg::data_t exp);
        bus_types_pkg::data_t rd;
        logic                 err;
        do_xfer(1'b0, a, '0, '0, lt, rd, err);
        check_err("pslverr", 1'b0, err);
        check_data("prdata", exp, rd);
    endtask

    task automatic expect_error(input logic wr, input bus_types_pkg::addr_t a);
        bus_types_pkg::data_t rd;
        logic                 err;
        do_xfer(wr, a, $random(seed), 4'hF, bus_types_pkg::lw, rd, err);
        check_err("pslverr", 1'b1, err);
        check_data("prdata", '0, rd);
    endtask

    task automatic stream_bytes(input int n);
        periph_types_pkg::byte_t b;
        for (int i = 0; i < n; i++) begin
            b = periph_types_pkg::byte_t'($random(seed));
            @(posedge CLOCK_50);
            sd_byte       <= b;
            sd_byte_valid <= 1'b1;
            if (!sector_avail) begin
                sector_model[sector_count[8:0]] = b;
                sector_count++;
                if (sector_count == `SD_BYTES) begin
                    sector_avail = 1'b1;
                end
            end
        end
        @(posedge CLOCK_50);
        sd_byte_valid <= 1'b0;
    endtask

    task automatic read_sector_byte(input int idx);
        bus_types_pkg::load_type_e lt;
        bus_types_pkg::data_t      lane;
        lt = ($random(seed) & 1) ? bus_types_pkg::lb : bus_types_pkg::lbu;
        lane = bus_types_pkg::data_t'(sector_model[idx[8:0]]) << (8 * idx[1:0]);
        read_ok(`SD_BASE + idx, lt, expected_load(lane, idx[1:0], lt));
    endtask

    initial begin
        bus_types_pkg::addr_t      a;
        bus_types_pkg::data_t      wd;
        bus_types_pkg::strb_t      s;
        bus_types_pkg::load_type_e lt;
        logic [1:0]                off;
        int                        k;

        KEY0          = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        pstrb         = '0;
        load_type     = bus_types_pkg::lw;
        key_code      = '0;
        key_valid     = 1'b0;
        sd_byte       = '0;
        sd_byte_valid = 1'b0;
        sector_count  = '0;
        sector_avail  = 1'b0;
        key_model     = '0;
        irq_model     = 1'b0;

        repeat (8) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(posedge CLOCK_50);
        @(posedge CLOCK_50);
        check_err("pready", 1'b0, pready);
        check_err("pslverr", 1'b0, pslverr);
        check_err("uart_valid", 1'b0, uart_valid);
        check_err("irq", 1'b0, irq);

        // RAM: full words first, so later reads never see unwritten lanes
        for (int i = 0; i < RAM_FILL; i++) begin
            word_list[i] = periph_types_pkg::ram_idx_t'($unsigned($random(seed)) % `RAM_WORDS);
            wd = $random(seed);
            ram_model[word_list[i]] = wd;
            write_ok(`RAM_BASE + {word_list[i], 2'b00}, wd, 4'hF);
        end
        for (int i = 0; i < RAM_RAND_WR; i++) begin
            k = $unsigned($random(seed)) % RAM_FILL;
            wd = $random(seed);
            s = bus_types_pkg::strb_t'($random(seed));
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    ram_model[word_list[k]][8*b +: 8] = wd[8*b +: 8];
                end
            end
            write_ok(`RAM_BASE + {word_list[k], 2'b00}, wd, s);
        end
        for (int i = 0; i < RAM_READS; i++) begin
            k = $unsigned($random(seed)) % RAM_FILL;
            lt = load_from_code($unsigned($random(seed)) % 5);
            off = 2'($random(seed));
            if (lt == bus_types_pkg::lw) begin
                off = 2'd0;
            end else if (lt == bus_types_pkg::lh || lt == bus_types_pkg::lhu) begin
                off[0] = 1'b0;
            end
            a = `RAM_BASE + {word_list[k], off};
            read_ok(a, lt, expected_load(ram_model[word_list[k]], off, lt));
        end

        // UART bytes, checked in order by the monitor
        for (int i = 0; i < UART_WRITES; i++) begin
            wd = $random(seed);
            uart_exp.push_back(wd[7:0]);
            write_ok(`UART_ADDR, wd, 4'hF);
        end

        // Keyboard event, interrupt and acknowledge
        key_model = periph_types_pkg::byte_t'($random(seed));
        @(posedge CLOCK_50);
        key_code  <= key_model;
        key_valid <= 1'b1;
        @(posedge CLOCK_50);
        key_valid <= 1'b0;
        irq_model = 1'b1;
        @(posedge CLOCK_50);
        check_err("irq", irq_model, irq);
        read_ok(`KEY_ADDR, bus_types_pkg::lw, {24'b0, key_model});
        write_ok(`IRQ_ACK_ADDR, 32'h1, 4'hF);
        irq_model = 1'b0;
        check_err("irq", irq_model, irq);

        // SD sector fill, overflow drop and rearm
        stream_bytes(`SD_BYTES);
        read_ok(`SD_AVAIL_ADDR, bus_types_pkg::lw, {31'b0, sector_avail});
        for (int i = 0; i < SD_READS; i++) begin
            read_sector_byte($unsigned($random(seed)) % `SD_BYTES);
        end
        stream_bytes(EXTRA_BYTES);
        for (int i = 0; i < 4; i++) begin
            read_sector_byte(i);
        end
        write_ok(`SD_AVAIL_ADDR, 32'h0, 4'hF);
        sector_count = '0;
        sector_avail = 1'b0;
        read_ok(`SD_AVAIL_ADDR, bus_types_pkg::lw, 32'h0);
        stream_bytes(REFILL_BYTES);
        for (int i = 0; i < REFILL_BYTES; i++) begin
            read_sector_byte(i);
        end

        // Unmapped addresses and writes to read-only targets
        expect_error(1'b0, 32'h0000_1000);
        expect_error(1'b1, 32'h0000_1000);
        expect_error(1'b0, 32'h0000_2010);
        expect_error(1'b1, 32'h0000_2010);
        expect_error(1'b0, `SD_BASE + `SD_BYTES);
        expect_error(1'b1, `SD_BASE + `SD_BYTES);
        expect_error(1'b0, 32'hFFFF_FFF0);
        expect_error(1'b1, 32'hFFFF_FFF0);
        expect_error(1'b1, `KEY_ADDR);
        expect_error(1'b1, `SD_BASE + 5);
        read_ok(`KEY_ADDR, bus_types_pkg::lw, {24'b0, key_model});
        read_ok(`RAM_BASE + {word_list[0], 2'b00}, bus_types_pkg::lw, ram_model[word_list[0]]);
        read_sector_byte(5);
        read_ok(`SD_AVAIL_ADDR, bus_types_pkg::lw, {31'b0, sector_avail});
        check_err("irq", irq_model, irq);

        @(posedge CLOCK_50);
        if (uart_exp.size() != 0) begin
            stop_on_error("some UART writes produced no uart_valid pulse");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
